//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = agen_tb
FILELIST = agen.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- agen.f
hdl/agen_uop_pkg.sv
hdl/agen_seg_pkg.sv
hdl/string_ptr_tracker.sv
hdl/seg_limit_check.sv
hdl/agen_stage.sv
hdl/me_latch.sv
hdl/agen_top.sv
verification/agen_checker.sv
verification/agen_tb.sv

//--- hdl/agen_seg_pkg.sv
package agen_seg_pkg;

   // x86 segment register order, codes 6 and 7 unused
   typedef enum logic [2:0] {
      es = 3'd0,
      cs = 3'd1,
      ss = 3'd2,
      ds = 3'd3,
      fs = 3'd4,
      gs = 3'd5
   } seg_id_e;

   // memory operand size, code 3 acts as a dword
   typedef enum logic [1:0] {
      sz_byte  = 2'd0,
      sz_word  = 2'd1,
      sz_dword = 2'd2
   } mem_size_e;

   // segment base is the 16-bit selector data moved up by this much
   localparam int seg_base_shift = 16;

   // bytes touched by one access
   // string pointers step by this count, negated when df is set
   function automatic logic [2:0] size_bytes(mem_size_e size);
      case (size)
         sz_byte: return 3'd1;
         sz_word: return 3'd2;
         default: return 3'd4;
      endcase
   endfunction

endpackage

//--- hdl/agen_stage.sv
`timescale 1ns/1ns

module agen_stage #(
   parameter int addr_w = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    v,
   input  logic                    ld,
   input  agen_uop_pkg::uop_kind_e kind,
   input  agen_uop_pkg::rd_sel_e   rd_sel,
   input  agen_uop_pkg::wr_sel_e   wr_sel,
   input  logic                    mem_rd,
   input  logic                    mem_wr,
   input  agen_seg_pkg::mem_size_e mem_size,
   input  agen_seg_pkg::seg_id_e   seg1,
   input  logic [15:0]             seg1_data,
   input  logic [15:0]             seg2_data,
   input  logic [addr_w-1:0]       base_disp,
   input  logic [addr_w-1:0]       sib_index,
   input  logic [addr_w-1:0]       sp,
   input  logic [addr_w-1:0]       a,
   input  logic [addr_w-1:0]       b,
   input  logic [addr_w-1:0]       intr_addr,
   input  logic                    use_imm1,
   input  logic                    df,
   input  logic                    ld_flags,
   input  logic                    df_affected,
   input  logic                    repne_steady,
   input  logic                    lim_wr_en,
   input  agen_seg_pkg::seg_id_e   lim_wr_seg,
   input  logic [addr_w-1:0]       lim_wr_data,
   output logic [addr_w-1:0]       rd_addr,
   output logic [addr_w-1:0]       wr_addr,
   output logic [addr_w-1:0]       a_out,
   output logic [addr_w-1:0]       b_out,
   output logic                    seg_exc,
   output logic                    jmp_stall,
   output logic                    df_update
);
   import agen_uop_pkg::*;
   import agen_seg_pkg::*;

   logic [addr_w-1:0] offset;
   logic [addr_w-1:0] seg1_base;
   logic [addr_w-1:0] seg2_base;
   logic [addr_w-1:0] seg1_addr;
   logic [addr_w-1:0] stack_addr;
   logic [addr_w-1:0] ptr_next;
   logic [addr_w-1:0] chk_offset;
   logic              cmps;
   logic              upd;
   seg_id_e           chk_seg;

   assign offset    = base_disp + sib_index;
   assign seg1_base = addr_w'(seg1_data) << seg_base_shift;
   assign seg2_base = addr_w'(seg2_data) << seg_base_shift;

   assign seg1_addr  = seg1_base + offset;
   assign stack_addr = seg2_base + sp;

   // pointer state only moves when the latch takes the uop
   assign cmps = is_cmps(kind);
   assign upd  = v && ld && cmps;

   string_ptr_tracker #(.addr_w(addr_w)) u_tracker (
      .clk      (clk),
      .rst_n    (rst_n),
      .upd      (upd),
      .second   (kind == uop_cmps_second),
      .steady   (repne_steady),
      .df       (df),
      .mem_size (mem_size),
      .a        (a),
      .seg1     (seg1),
      .ptr_next (ptr_next),
      .str_seg  ()
   );

   always_comb begin
      case (rd_sel)
         rd_seg1:   rd_addr = seg1_addr;
         rd_stack:  rd_addr = stack_addr;
         rd_intr:   rd_addr = intr_addr;
         default:   rd_addr = seg1_base + ptr_next;
      endcase
   end

   assign wr_addr = (wr_sel == wr_stack) ? stack_addr : seg1_addr;

   // limit check follows the read source
   always_comb begin
      chk_seg = seg1;
      case (rd_sel)
         rd_string: chk_offset = ptr_next;
         rd_stack: begin
            chk_offset = sp;
            chk_seg    = ss;
         end
         default:   chk_offset = offset;
      endcase
   end

   seg_limit_check #(.addr_w(addr_w)) u_limit (
      .clk         (clk),
      .rst_n       (rst_n),
      .v           (v),
      .mem_rd      (mem_rd),
      .mem_wr      (mem_wr),
      .seg         (chk_seg),
      .offset      (chk_offset),
      .mem_size    (mem_size),
      .lim_wr_en   (lim_wr_en),
      .lim_wr_seg  (lim_wr_seg),
      .lim_wr_data (lim_wr_data),
      .seg_exc     (seg_exc)
   );

   assign a_out = (cmps && repne_steady) ? ptr_next : a;
   assign b_out = use_imm1 ? addr_w'(1) : b;

   assign jmp_stall = v && (kind inside {uop_jmp, uop_near_ret, uop_far_ret});
   assign df_update = v && ld_flags && df_affected;

   // string reads only come from a cmps pair
   str_rd_cmps_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (v && (rd_sel == rd_string)) |-> cmps
   ) else $error("string read address selected outside cmps");

endmodule

//--- hdl/agen_top.sv
`timescale 1ns/1ns

module agen_top #(
   parameter int addr_w = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    v,
   input  agen_uop_pkg::uop_kind_e kind,
   input  agen_uop_pkg::rd_sel_e   rd_sel,
   input  agen_uop_pkg::wr_sel_e   wr_sel,
   input  logic                    mem_rd,
   input  logic                    mem_wr,
   input  agen_seg_pkg::mem_size_e mem_size,
   input  agen_seg_pkg::seg_id_e   seg1,
   input  logic [15:0]             seg1_data,
   input  logic [15:0]             seg2_data,
   input  logic [addr_w-1:0]       base_disp,
   input  logic [addr_w-1:0]       sib_index,
   input  logic [addr_w-1:0]       sp,
   input  logic [addr_w-1:0]       a,
   input  logic [addr_w-1:0]       b,
   input  logic                    use_imm1,
   input  logic                    df,
   input  logic                    ld_flags,
   input  logic                    df_affected,
   input  logic [addr_w-1:0]       intr_addr,
   input  logic                    repne_steady,
   input  logic                    lim_wr_en,
   input  agen_seg_pkg::seg_id_e   lim_wr_seg,
   input  logic [addr_w-1:0]       lim_wr_data,
   input  logic                    ld,
   output logic                    v_me,
   output logic [addr_w-1:0]       rd_addr_me,
   output logic [addr_w-1:0]       wr_addr_me,
   output logic [addr_w-1:0]       a_me,
   output logic [addr_w-1:0]       b_me,
   output logic                    seg_exc_me,
   output logic                    jmp_stall_me,
   output logic                    df_update_me
);

   logic [addr_w-1:0] rd_addr;
   logic [addr_w-1:0] wr_addr;
   logic [addr_w-1:0] a_out;
   logic [addr_w-1:0] b_out;
   logic              seg_exc;
   logic              jmp_stall;
   logic              df_update;

   agen_stage #(.addr_w(addr_w)) u_stage (
      .clk          (clk),
      .rst_n        (rst_n),
      .v            (v),
      .ld           (ld),
      .kind         (kind),
      .rd_sel       (rd_sel),
      .wr_sel       (wr_sel),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_size     (mem_size),
      .seg1         (seg1),
      .seg1_data    (seg1_data),
      .seg2_data    (seg2_data),
      .base_disp    (base_disp),
      .sib_index    (sib_index),
      .sp           (sp),
      .a            (a),
      .b            (b),
      .intr_addr    (intr_addr),
      .use_imm1     (use_imm1),
      .df           (df),
      .ld_flags     (ld_flags),
      .df_affected  (df_affected),
      .repne_steady (repne_steady),
      .lim_wr_en    (lim_wr_en),
      .lim_wr_seg   (lim_wr_seg),
      .lim_wr_data  (lim_wr_data),
      .rd_addr      (rd_addr),
      .wr_addr      (wr_addr),
      .a_out        (a_out),
      .b_out        (b_out),
      .seg_exc      (seg_exc),
      .jmp_stall    (jmp_stall),
      .df_update    (df_update)
   );

   // one cycle toward the memory stage
   me_latch #(.addr_w(addr_w)) u_latch (
      .clk          (clk),
      .rst_n        (rst_n),
      .ld           (ld),
      .v            (v),
      .rd_addr      (rd_addr),
      .wr_addr      (wr_addr),
      .a_out        (a_out),
      .b_out        (b_out),
      .seg_exc      (seg_exc),
      .jmp_stall    (jmp_stall),
      .df_update    (df_update),
      .v_me         (v_me),
      .rd_addr_me   (rd_addr_me),
      .wr_addr_me   (wr_addr_me),
      .a_me         (a_me),
      .b_me         (b_me),
      .seg_exc_me   (seg_exc_me),
      .jmp_stall_me (jmp_stall_me),
      .df_update_me (df_update_me)
   );

endmodule

//--- hdl/agen_uop_pkg.sv
package agen_uop_pkg;

   // micro-op kinds seen by the address stage
   // codes 6 and 7 are never issued
   typedef enum logic [2:0] {
      uop_plain       = 3'd0,
      uop_jmp         = 3'd1,
      uop_near_ret    = 3'd2,
      uop_far_ret     = 3'd3,
      uop_cmps_first  = 3'd4,
      uop_cmps_second = 3'd5
   } uop_kind_e;

   // read address source
   typedef enum logic [1:0] {
      rd_seg1   = 2'd0,
      rd_stack  = 2'd1,
      rd_intr   = 2'd2,
      rd_string = 2'd3
   } rd_sel_e;

   // write address source
   typedef enum logic {
      wr_seg1  = 1'b0,
      wr_stack = 1'b1
   } wr_sel_e;

   // either half of a repne cmps pair
   function automatic logic is_cmps(uop_kind_e kind);
      return (kind == uop_cmps_first) || (kind == uop_cmps_second);
   endfunction

endpackage

//--- hdl/me_latch.sv
`timescale 1ns/1ns

module me_latch #(
   parameter int addr_w = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ld,
   input  logic              v,
   input  logic [addr_w-1:0] rd_addr,
   input  logic [addr_w-1:0] wr_addr,
   input  logic [addr_w-1:0] a_out,
   input  logic [addr_w-1:0] b_out,
   input  logic              seg_exc,
   input  logic              jmp_stall,
   input  logic              df_update,
   output logic              v_me,
   output logic [addr_w-1:0] rd_addr_me,
   output logic [addr_w-1:0] wr_addr_me,
   output logic [addr_w-1:0] a_me,
   output logic [addr_w-1:0] b_me,
   output logic              seg_exc_me,
   output logic              jmp_stall_me,
   output logic              df_update_me
);

   // ld low is a memory stage stall, everything holds
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         v_me         <= 1'b0;
         rd_addr_me   <= '0;
         wr_addr_me   <= '0;
         a_me         <= '0;
         b_me         <= '0;
         seg_exc_me   <= 1'b0;
         jmp_stall_me <= 1'b0;
         df_update_me <= 1'b0;
      end else if (ld) begin
         v_me         <= v;
         rd_addr_me   <= rd_addr;
         wr_addr_me   <= wr_addr;
         a_me         <= a_out;
         b_me         <= b_out;
         seg_exc_me   <= seg_exc;
         jmp_stall_me <= jmp_stall;
         df_update_me <= df_update;
      end
   end

   // a limit fault is only raised for a live uop
   exc_valid_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      seg_exc_me |-> v_me
   ) else $error("segment exception latched without valid");

endmodule

//--- hdl/seg_limit_check.sv
`timescale 1ns/1ns

module seg_limit_check #(
   parameter int addr_w = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    v,
   input  logic                    mem_rd,
   input  logic                    mem_wr,
   input  agen_seg_pkg::seg_id_e   seg,
   input  logic [addr_w-1:0]       offset,
   input  agen_seg_pkg::mem_size_e mem_size,
   input  logic                    lim_wr_en,
   input  agen_seg_pkg::seg_id_e   lim_wr_seg,
   input  logic [addr_w-1:0]       lim_wr_data,
   output logic                    seg_exc
);
   import agen_seg_pkg::*;

   logic [addr_w-1:0] limit [8];
   logic [addr_w:0]   last_byte;
   logic [addr_w:0]   seg_limit;
   logic              access;

   // one limit register per segment id, unused ids included
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            limit[i] <= '1;
         end
      end else if (lim_wr_en) begin
         limit[lim_wr_seg] <= lim_wr_data;
      end
   end

   assign access = v && (mem_rd || mem_wr);

   // extra bit keeps a wrap past the top from looking in range
   assign last_byte = {1'b0, offset} + (addr_w + 1)'(size_bytes(mem_size))
                      - (addr_w + 1)'(1);
   assign seg_limit = {1'b0, limit[seg]};

   // limit is inclusive
   assign seg_exc = access && (last_byte > seg_limit);

endmodule

//--- hdl/string_ptr_tracker.sv
`timescale 1ns/1ns

module string_ptr_tracker #(
   parameter int addr_w = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  upd,
   input  logic                  second,
   input  logic                  steady,
   input  logic                  df,
   input  agen_seg_pkg::mem_size_e mem_size,
   input  logic [addr_w-1:0]     a,
   input  agen_seg_pkg::seg_id_e seg1,
   output logic [addr_w-1:0]     ptr_next,
   output agen_seg_pkg::seg_id_e str_seg
);
   import agen_seg_pkg::*;

   logic [addr_w-1:0] src_ptr;
   logic [addr_w-1:0] dst_ptr;
   logic [addr_w-1:0] saved_ptr;
   logic [addr_w-1:0] step;
   logic [2:0]        nbytes;
   seg_id_e           src_seg;
   seg_id_e           dst_seg;
   seg_id_e           saved_seg;

   assign nbytes = size_bytes(mem_size);

   // two's complement step when walking downward
   assign step = df ? (~addr_w'(nbytes) + addr_w'(1)) : addr_w'(nbytes);

   // first uop walks the source, second the destination
   assign saved_ptr = second ? dst_ptr : src_ptr;
   assign saved_seg = second ? dst_seg : src_seg;

   // a fresh start takes the pointer straight from operand a
   assign ptr_next = steady ? (saved_ptr + step) : a;
   assign str_seg  = steady ? saved_seg : seg1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         src_ptr <= '0;
         dst_ptr <= '0;
         src_seg <= es;
         dst_seg <= es;
      end else if (upd) begin
         if (second) begin
            dst_ptr <= ptr_next;
            dst_seg <= seg1;
         end else begin
            src_ptr <= ptr_next;
            src_seg <= seg1;
         end
      end
   end

endmodule

//--- verification/agen_checker.sv
`timescale 1ns/1ns

module agen_checker #(
   parameter int addr_w = 32
) (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    v,
   input agen_uop_pkg::uop_kind_e kind,
   input agen_uop_pkg::rd_sel_e   rd_sel,
   input agen_uop_pkg::wr_sel_e   wr_sel,
   input logic                    mem_rd,
   input logic                    mem_wr,
   input agen_seg_pkg::mem_size_e mem_size,
   input agen_seg_pkg::seg_id_e   seg1,
   input logic [15:0]             seg1_data,
   input logic [15:0]             seg2_data,
   input logic [addr_w-1:0]       base_disp,
   input logic [addr_w-1:0]       sib_index,
   input logic [addr_w-1:0]       sp,
   input logic [addr_w-1:0]       a,
   input logic [addr_w-1:0]       b,
   input logic                    use_imm1,
   input logic                    df,
   input logic                    ld_flags,
   input logic                    df_affected,
   input logic [addr_w-1:0]       intr_addr,
   input logic                    repne_steady,
   input logic                    lim_wr_en,
   input agen_seg_pkg::seg_id_e   lim_wr_seg,
   input logic [addr_w-1:0]       lim_wr_data,
   input logic                    ld,
   input logic                    v_me,
   input logic [addr_w-1:0]       rd_addr_me,
   input logic [addr_w-1:0]       wr_addr_me,
   input logic [addr_w-1:0]       a_me,
   input logic [addr_w-1:0]       b_me,
   input logic                    seg_exc_me,
   input logic                    jmp_stall_me,
   input logic                    df_update_me
);
   import agen_uop_pkg::*;
   import agen_seg_pkg::*;

   int errors = 0;
   int checks = 0;

   logic [addr_w-1:0] lim [8];
   logic [addr_w-1:0] src_ptr;
   logic [addr_w-1:0] dst_ptr;

   // predicted latch contents
   logic              exp_v;
   logic [addr_w-1:0] exp_rd;
   logic [addr_w-1:0] exp_wr;
   logic [addr_w-1:0] exp_a;
   logic [addr_w-1:0] exp_b;
   logic              exp_exc;
   logic              exp_jmp;
   logic              exp_dfu;

   function automatic logic [addr_w-1:0] byte_count(mem_size_e size);
      case (size)
         sz_byte: return addr_w'(1);
         sz_word: return addr_w'(2);
         default: return addr_w'(4);
      endcase
   endfunction

   task automatic compare_word(string name, logic [addr_w-1:0] exp, logic [addr_w-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic compare_flag(string name, logic exp, logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %0t ns %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   always @(posedge clk or negedge rst_n) begin
      logic [addr_w-1:0] offset;
      logic [addr_w-1:0] s1_base;
      logic [addr_w-1:0] s2_base;
      logic [addr_w-1:0] nb;
      logic [addr_w-1:0] step;
      logic [addr_w-1:0] ptr;
      logic [addr_w-1:0] rd_exp;
      logic [addr_w-1:0] chk_off;
      logic [addr_w:0]   last;
      seg_id_e           chk_seg;
      logic              cmps;
      logic              exc;
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            lim[i] = '1;
         end
         src_ptr = '0;
         dst_ptr = '0;
         exp_v   = 1'b0;
         exp_rd  = '0;
         exp_wr  = '0;
         exp_a   = '0;
         exp_b   = '0;
         exp_exc = 1'b0;
         exp_jmp = 1'b0;
         exp_dfu = 1'b0;
      end else begin
         offset  = base_disp + sib_index;
         s1_base = addr_w'({seg1_data, 16'h0000});
         s2_base = addr_w'({seg2_data, 16'h0000});
         nb      = byte_count(mem_size);
         step    = df ? ('0 - nb) : nb;
         cmps    = (kind == uop_cmps_first) || (kind == uop_cmps_second);
         // steady uops walk their own saved pointer
         if (repne_steady) begin
            ptr = ((kind == uop_cmps_second) ? dst_ptr : src_ptr) + step;
         end else begin
            ptr = a;
         end
         case (rd_sel)
            rd_seg1:  rd_exp = s1_base + offset;
            rd_stack: rd_exp = s2_base + sp;
            rd_intr:  rd_exp = intr_addr;
            default:  rd_exp = s1_base + ptr;
         endcase
         chk_off = (rd_sel == rd_string) ? ptr : ((rd_sel == rd_stack) ? sp : offset);
         chk_seg = (rd_sel == rd_stack) ? ss : seg1;
         last    = {1'b0, chk_off} + {1'b0, nb} - (addr_w + 1)'(1);
         exc     = v && (mem_rd || mem_wr) && (last > {1'b0, lim[chk_seg]});
         if (ld) begin
            exp_v   = v;
            exp_rd  = rd_exp;
            exp_wr  = (wr_sel == wr_stack) ? (s2_base + sp) : (s1_base + offset);
            exp_a   = (cmps && repne_steady) ? ptr : a;
            exp_b   = use_imm1 ? addr_w'(1) : b;
            exp_exc = exc;
            exp_jmp = v && (kind == uop_jmp || kind == uop_near_ret || kind == uop_far_ret);
            exp_dfu = v && ld_flags && df_affected;
            if (v && cmps) begin
               if (kind == uop_cmps_second) begin
                  dst_ptr = ptr;
               end else begin
                  src_ptr = ptr;
               end
            end
         end
         // table write lands after this cycle's check
         if (lim_wr_en) begin
            lim[lim_wr_seg] = lim_wr_data;
         end
      end
   end

   // latch outputs settle well before the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         compare_flag("v_me", exp_v, v_me);
         compare_word("rd_addr_me", exp_rd, rd_addr_me);
         compare_word("wr_addr_me", exp_wr, wr_addr_me);
         compare_word("a_me", exp_a, a_me);
         compare_word("b_me", exp_b, b_me);
         compare_flag("seg_exc_me", exp_exc, seg_exc_me);
         compare_flag("jmp_stall_me", exp_jmp, jmp_stall_me);
         compare_flag("df_update_me", exp_dfu, df_update_me);
      end
   end

endmodule

//--- verification/agen_tb.sv
`timescale 1ns/1ns

module agen_tb;
   import agen_uop_pkg::*;
   import agen_seg_pkg::*;

   localparam int addr_w = 32;
   localparam int n_uops = 400;
   // one uop per cycle, five cycles each leaves room for reset and drain
   localparam int timeout_cycles = n_uops * 5;

   logic              clk;
   logic              rst_n;
   logic              v;
   uop_kind_e         kind;
   rd_sel_e           rd_sel;
   wr_sel_e           wr_sel;
   logic              mem_rd;
   logic              mem_wr;
   mem_size_e         mem_size;
   seg_id_e           seg1;
   logic [15:0]       seg1_data;
   logic [15:0]       seg2_data;
   logic [addr_w-1:0] base_disp;
   logic [addr_w-1:0] sib_index;
   logic [addr_w-1:0] sp;
   logic [addr_w-1:0] a;
   logic [addr_w-1:0] b;
   logic              use_imm1;
   logic              df;
   logic              ld_flags;
   logic              df_affected;
   logic [addr_w-1:0] intr_addr;
   logic              repne_steady;
   logic              lim_wr_en;
   seg_id_e           lim_wr_seg;
   logic [addr_w-1:0] lim_wr_data;
   logic              ld;
   logic              v_me;
   logic [addr_w-1:0] rd_addr_me;
   logic [addr_w-1:0] wr_addr_me;
   logic [addr_w-1:0] a_me;
   logic [addr_w-1:0] b_me;
   logic              seg_exc_me;
   logic              jmp_stall_me;
   logic              df_update_me;
   int                cycles = 0;

   agen_top #(.addr_w(addr_w)) dut0 (.*);

   agen_checker #(.addr_w(addr_w)) check0 (.*);

   always #2 clk = ~clk;

   // idle bubble with the latch open
   task automatic clear_inputs();
      v            = 1'b0;
      kind         = uop_plain;
      rd_sel       = rd_seg1;
      wr_sel       = wr_seg1;
      mem_rd       = 1'b0;
      mem_wr       = 1'b0;
      mem_size     = sz_byte;
      seg1         = ds;
      seg1_data    = '0;
      seg2_data    = '0;
      base_disp    = '0;
      sib_index    = '0;
      sp           = '0;
      a            = '0;
      b            = '0;
      use_imm1     = 1'b0;
      df           = 1'b0;
      ld_flags     = 1'b0;
      df_affected  = 1'b0;
      intr_addr    = '0;
      repne_steady = 1'b0;
      lim_wr_en    = 1'b0;
      lim_wr_seg   = es;
      lim_wr_data  = '0;
      ld           = 1'b1;
   endtask

   task automatic drive_random_uop();
      int          pick;
      logic [31:0] r;
      pick = $urandom_range(0, 9);
      r    = $urandom;
      v    = ($urandom_range(0, 7) != 0);
      if (pick < 5) begin
         kind         = (pick == 4) ? uop_kind_e'(3'($urandom_range(1, 3))) : uop_plain;
         rd_sel       = rd_sel_e'(2'($urandom_range(0, 2)));
         // steady outside a cmps pair must leave operand a alone
         repne_steady = r[18];
      end else begin
         kind   = r[17] ? uop_cmps_second : uop_cmps_first;
         rd_sel = rd_string;
         // a string run restarts now and then
         repne_steady = ($urandom_range(0, 7) != 0);
      end
      mem_rd      = r[0];
      mem_wr      = r[1];
      use_imm1    = r[2];
      df          = r[3];
      ld_flags    = r[4];
      df_affected = r[5];
      wr_sel      = wr_sel_e'(r[6]);
      mem_size    = mem_size_e'(r[8:7]);
      seg1        = seg_id_e'(r[11:9]);
      lim_wr_seg  = seg_id_e'(r[14:12]);
      lim_wr_en   = (r[16:15] == 2'b00);
      seg1_data   = 16'($urandom);
      seg2_data   = 16'($urandom);
      // shifted values spread offsets and limits over many magnitudes
      base_disp   = $urandom >> $urandom_range(0, 31);
      sib_index   = $urandom >> $urandom_range(8, 31);
      sp          = $urandom >> $urandom_range(0, 31);
      a           = $urandom;
      b           = $urandom;
      intr_addr   = $urandom;
      lim_wr_data = $urandom >> $urandom_range(0, 31);
      ld          = ($urandom_range(0, 9) >= 3);
   endtask

   initial begin
      clk = 1'b0;
      void'($urandom(32'h7fc));
      clear_inputs();
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < n_uops; i++) begin
         drive_random_uop();
         @(posedge clk);
         #1;
      end
      clear_inputs();
      repeat (2) @(posedge clk);
      @(negedge clk);
      #1;
      $display("checks %0d errors %0d", check0.checks, check0.errors);
      if (check0.errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout after %0d cycles, stimulus did not finish", cycles);
         $display("Verification failed");
         $finish;
      end
   end

endmodule
